//--- all.f
+incdir+common
common/zx_bus_pkg.sv
common/zx_mem_pkg.sv
paging/mem_map.sv
paging/page_regs.sv
src/mem_req_queue.sv
src/sdram_port.sv
src/zx_mem_top.sv
dv/tb_clkgen.sv
dv/tb_zx_mem.sv

//--- dv/tb_zx_mem.sv
/*
 * Memory subsystem testbench
 * SDRAM model with random ack delay, stimulus table,
 * compare task and bounded waits
 */
`timescale 1ns/100ps

module tb_zx_mem;

	typedef enum logic [1:0] {op_io, op_wr, op_rd} op_e;

	typedef struct {
		zx_bus_pkg::mem_mode_e mode;
		op_e                   op;
		logic [15:0]           addr;
		logic [7:0]            data;
		logic                  has_exp;
		zx_mem_pkg::ram_addr_t exp_addr;
		logic [7:0]            exp_byte;
		logic                  no_wait;    // Next row follows without waiting
	} stim_row_t;

	localparam zx_bus_pkg::mem_mode_e mode_128 = zx_bus_pkg::std128;
	localparam zx_bus_pkg::mem_mode_e mode_48  = zx_bus_pkg::zx48;
	localparam zx_bus_pkg::mem_mode_e mode_p3  = zx_bus_pkg::plus3;
	localparam zx_mem_pkg::ram_addr_t no_req   = 24'hFFFFFF;    // Never a valid address
	localparam int ready_timeout = 200;
	localparam int reset_timeout = 20;

	logic                  clk_sys;
	logic                  reset;
	logic                  restart;
	zx_bus_pkg::cpu_bus_t  cpu_bus;
	zx_bus_pkg::mem_mode_e mem_mode;
	logic                  sdram_ack;
	logic [15:0]           sdram_dout;
	logic                  sdram_req;
	zx_mem_pkg::ram_addr_t sdram_addr;
	logic                  sdram_we;
	logic [7:0]            sdram_din;
	logic                  ram_ready;
	logic [7:0]            ram_dout;

	logic [15:0]          sdram_words [logic [22:0]];    // Sparse word store
	zx_mem_pkg::mem_req_t rec_q [$];                     // Completed at the model
	zx_mem_pkg::mem_req_t exp_q [$];
	stim_row_t            stim_table [$];

	// +3 all-RAM bank per window by 1FFD bits 2..1
	int special_bank [4][4] = '{'{0, 1, 2, 3}, '{4, 5, 6, 7}, '{4, 5, 6, 3}, '{4, 7, 6, 3}};

	tb_clkgen #(.RESET_CYCLES(5)) u_clkgen (
		.restart (restart),
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	zx_mem_top u_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_bus    (cpu_bus),
		.mem_mode   (mem_mode),
		.sdram_ack  (sdram_ack),
		.sdram_dout (sdram_dout),
		.sdram_req  (sdram_req),
		.sdram_addr (sdram_addr),
		.sdram_we   (sdram_we),
		.sdram_din  (sdram_din),
		.ram_ready  (ram_ready),
		.ram_dout   (ram_dout)
	);

	// Unwritten words mix every address bit
	function automatic logic [15:0] fill_word(input logic [22:0] waddr);
		return waddr[15:0] ^ {waddr[22:16], waddr[22:14]};
	endfunction

	function automatic logic [7:0] fill_byte(input zx_mem_pkg::ram_addr_t addr);
		logic [15:0] word;
		word = fill_word(addr[23:1]);
		return addr[0] ? word[15:8] : word[7:0];
	endfunction

	function automatic zx_mem_pkg::ram_addr_t rom_loc(input int bank, input logic [15:0] addr);
		return {3'b000, 3'b101, 4'(bank), addr[13:0]};    // ROM region code 101
	endfunction

	function automatic zx_mem_pkg::ram_addr_t ram_loc(input int bank, input logic [15:0] addr);
		return {3'b000, 3'b000, 4'(bank), addr[13:0]};
	endfunction

	// ==================================================
	// SDRAM controller model
	// ==================================================
	initial begin : sdram_model
		int unsigned          delay;
		logic                 busy;
		logic [22:0]          waddr;
		logic [15:0]          word;
		zx_mem_pkg::mem_req_t rec;
		delay = $urandom(9722);    // Seed for the whole run
		busy = 1'b0;
		sdram_ack = 1'b0;
		sdram_dout = '0;
		forever begin
			@(posedge clk_sys);
			if (reset) begin
				busy = 1'b0;
				sdram_ack <= 1'b0;
			end else if (busy) begin
				delay = delay - 1;
				if (delay == 0) begin
					waddr = sdram_addr[23:1];
					word = sdram_words.exists(waddr) ? sdram_words[waddr] : fill_word(waddr);
					if (sdram_we) begin
						if (sdram_addr[0]) word[15:8] = sdram_din;
						else word[7:0] = sdram_din;
						sdram_words[waddr] = word;
						rec.data = sdram_din;
					end else begin
						sdram_dout <= word;
						rec.data = sdram_addr[0] ? word[15:8] : word[7:0];
					end
					rec.addr = sdram_addr;
					rec.we = sdram_we;
					rec_q.push_back(rec);
					sdram_ack <= sdram_req;
					busy = 1'b0;
				end
			end else if (sdram_req != sdram_ack) begin
				busy = 1'b1;
				delay = ($urandom % 6) + 1;    // 1 to 6 cycles
			end
		end
	end

	// ==================================================
	// Checking and waits
	// ==================================================
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	task automatic wait_reset_done();
		int cycles;
		cycles = 0;
		@(negedge clk_sys);
		while (reset) begin
			if (cycles == reset_timeout) fail_run("reset never went low");
			cycles++;
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk_sys);
		while (!ram_ready) begin
			if (cycles == ready_timeout) fail_run("ram_ready never returned high");
			cycles++;
			@(negedge clk_sys);
		end
	endtask

	// Every request expected so far must have reached the model in order
	task automatic compare_records();
		zx_mem_pkg::mem_req_t got;
		zx_mem_pkg::mem_req_t want;
		check_value("request count", rec_q.size(), exp_q.size());
		while (exp_q.size() > 0) begin
			got = rec_q.pop_front();
			want = exp_q.pop_front();
			check_value("sdram_addr", got.addr, want.addr);
			check_value("sdram_we", got.we, want.we);
			check_value("sdram byte", got.data, want.data);
		end
	endtask

	task automatic restart_in_mode(input zx_bus_pkg::mem_mode_e mode);
		@(posedge clk_sys);
		mem_mode <= mode;
		restart <= 1'b1;
		@(posedge clk_sys);
		restart <= 1'b0;
		wait_reset_done();
		check_value("ram_ready", ram_ready, 1);
		check_value("sdram_req", sdram_req, 0);
	endtask

	task automatic apply_row(input stim_row_t row);
		zx_bus_pkg::cpu_bus_t bus;
		zx_mem_pkg::mem_req_t want;
		bus = '0;
		bus.addr = row.addr;
		bus.data = row.data;
		case (row.op)
			op_io: begin
				bus.iorq = 1'b1;
				bus.wr = 1'b1;
			end
			op_wr: begin
				bus.mreq = 1'b1;
				bus.wr = 1'b1;
			end
			default: begin
				bus.mreq = 1'b1;
				bus.rd = 1'b1;
			end
		endcase
		if (row.has_exp) begin
			want.addr = row.exp_addr;
			want.we = (row.op == op_wr);
			want.data = (row.op == op_wr) ? row.data : row.exp_byte;
			exp_q.push_back(want);
		end
		@(posedge clk_sys);
		cpu_bus <= bus;
		@(posedge clk_sys);
		cpu_bus <= '{addr: row.addr, data: row.data, default: 1'b0};    // Strobes off
		if (!row.no_wait) begin
			wait_ready();
			compare_records();
			if (row.op == op_rd) check_value("ram_dout", ram_dout, row.exp_byte);
		end
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================
	task automatic add_row(input zx_bus_pkg::mem_mode_e mode, input op_e op,
		input logic [15:0] addr, input logic [7:0] data, input zx_mem_pkg::ram_addr_t exp_addr,
		input logic [7:0] exp_byte, input logic no_wait);
		stim_row_t row;
		row = '{mode, op, addr, data, exp_addr != no_req, exp_addr, exp_byte, no_wait};
		stim_table.push_back(row);
	endtask

	task automatic io_write(input zx_bus_pkg::mem_mode_e mode, input logic [15:0] port,
		input logic [7:0] data);
		add_row(mode, op_io, port, data, no_req, 8'h00, 1'b0);
	endtask

	task automatic read_rom(input zx_bus_pkg::mem_mode_e mode, input logic [15:0] addr,
		input int bank);
		add_row(mode, op_rd, addr, 8'h00, rom_loc(bank, addr),
			fill_byte(rom_loc(bank, addr)), 1'b0);
	endtask

	task automatic write_ram(input zx_bus_pkg::mem_mode_e mode, input logic [15:0] addr,
		input logic [7:0] data, input int bank, input logic no_wait);
		add_row(mode, op_wr, addr, data, ram_loc(bank, addr), 8'h00, no_wait);
	endtask

	task automatic read_ram(input zx_bus_pkg::mem_mode_e mode, input logic [15:0] addr,
		input int bank, input logic [7:0] exp_byte);
		add_row(mode, op_rd, addr, 8'h00, ram_loc(bank, addr), exp_byte, 1'b0);
	endtask

	task automatic build_table();
		logic [15:0] addr;
		// 128K ROM select and 7FFD banking
		read_rom(mode_128, 16'h0123, 6);
		io_write(mode_128, 16'h7FFD, 8'h10);
		read_rom(mode_128, 16'h1ABC, 7);
		for (int b = 0; b < 8; b++) begin
			io_write(mode_128, 16'h7FFD, 8'(b));
			write_ram(mode_128, 16'hC010 + 16'(b), 8'hA0 + 8'(b), b, 1'b0);
		end
		read_ram(mode_128, 16'hC017, 7, 8'hA7);
		write_ram(mode_128, 16'h4000, 8'h55, 5, 1'b0);
		write_ram(mode_128, 16'h8001, 8'h66, 2, 1'b0);
		// Both byte lanes
		write_ram(mode_128, 16'h4100, 8'h3C, 5, 1'b0);
		write_ram(mode_128, 16'h4101, 8'hC3, 5, 1'b0);
		read_ram(mode_128, 16'h4100, 5, 8'h3C);
		read_ram(mode_128, 16'h4101, 5, 8'hC3);
		read_ram(mode_128, 16'h4000, 5, 8'h55);
		// Dropped ROM write leaves ROM content untouched
		add_row(mode_128, op_wr, 16'h0200, 8'hEE, no_req, 8'h00, 1'b0);
		write_ram(mode_128, 16'h8002, 8'h77, 2, 1'b0);
		read_rom(mode_128, 16'h0200, 6);
		// Locked 7FFD ignores a later write
		io_write(mode_128, 16'h7FFD, 8'h23);
		write_ram(mode_128, 16'hC020, 8'h91, 3, 1'b0);
		io_write(mode_128, 16'h7FFD, 8'h05);
		write_ram(mode_128, 16'hC021, 8'h92, 3, 1'b0);
		// Write burst
		write_ram(mode_128, 16'h4200, 8'hB0, 5, 1'b1);
		write_ram(mode_128, 16'h8203, 8'hB1, 2, 1'b1);
		write_ram(mode_128, 16'hC204, 8'hB2, 3, 1'b1);
		write_ram(mode_128, 16'h4205, 8'hB3, 5, 1'b0);
		read_ram(mode_128, 16'h8203, 2, 8'hB1);
		// 48K
		read_rom(mode_48, 16'h0042, 15);
		io_write(mode_48, 16'h7FFD, 8'h07);
		write_ram(mode_48, 16'hC005, 8'h48, 0, 1'b0);
		add_row(mode_48, op_wr, 16'h3FFF, 8'h11, no_req, 8'h00, 1'b0);
		// +3 ROM formula
		read_rom(mode_p3, 16'h0100, 8);
		io_write(mode_p3, 16'h7FFD, 8'h10);
		read_rom(mode_p3, 16'h0100, 9);
		io_write(mode_p3, 16'h1FFD, 8'h04);
		read_rom(mode_p3, 16'h0101, 11);
		io_write(mode_p3, 16'h7FFD, 8'h00);
		read_rom(mode_p3, 16'h0102, 10);
		// +3 all-RAM modes
		for (int m = 0; m < 4; m++) begin
			io_write(mode_p3, 16'h1FFD, {5'b00000, 2'(m), 1'b1});
			for (int w = 0; w < 4; w++) begin
				addr = {2'(w), 14'(16'h30 + m * 4 + w)};
				write_ram(mode_p3, addr, 8'(8'h80 + m * 4 + w), special_bank[m][w], 1'b0);
			end
		end
		read_ram(mode_p3, 16'h403D, 7, 8'h8D);
		io_write(mode_p3, 16'h1FFD, 8'h00);
		read_rom(mode_p3, 16'h0103, 8);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		zx_bus_pkg::mem_mode_e cur_mode;
		restart = 1'b0;
		cpu_bus = '0;
		mem_mode = mode_128;
		cur_mode = mode_128;
		build_table();
		wait_reset_done();
		foreach (stim_table[i]) begin
			if (stim_table[i].mode != cur_mode) begin
				restart_in_mode(stim_table[i].mode);    // Mode is only taken at reset
				cur_mode = stim_table[i].mode;
			end
			apply_row(stim_table[i]);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

//--- dv/tb_clkgen.sv
/*
 * Testbench clock and reset source
 * 100 ns clock, reset held for a fixed number of cycles
 */
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int RESET_CYCLES = 5
) (
	input  logic restart,    // Re-enter reset on the next edge
	output logic clk_sys,
	output logic reset
);

	int unsigned hold = RESET_CYCLES;

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (restart) begin
			hold <= RESET_CYCLES;
		end else if (hold != 0) begin
			hold <= hold - 1;
		end
	end

	assign reset = (hold != 0);

endmodule

//--- src/zx_mem_top.sv
/*
 * Memory subsystem top level
 * Paging unit, request queue and SDRAM port
 */
`timescale 1ns/100ps
`include "zx_settings.svh"

module zx_mem_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_bus_pkg::cpu_bus_t  cpu_bus,
	input  zx_bus_pkg::mem_mode_e mem_mode,
	input  logic                  sdram_ack,
	input  logic [15:0]           sdram_dout,
	output logic                  sdram_req,
	output zx_mem_pkg::ram_addr_t sdram_addr,
	output logic                  sdram_we,
	output logic [7:0]            sdram_din,
	output logic                  ram_ready,
	output logic [7:0]            ram_dout
);

	logic                 push;
	zx_mem_pkg::mem_req_t push_req;
	zx_mem_pkg::mem_req_t head;
	logic                 not_empty;
	logic                 queue_empty;
	logic                 pop;

	page_regs u_page_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_bus  (cpu_bus),
		.mem_mode (mem_mode),
		.push     (push),
		.push_req (push_req)
	);

	mem_req_queue #(
		.DEPTH (`ZX_REQ_DEPTH)
	) u_req_queue (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.push      (push),
		.push_req  (push_req),
		.pop       (pop),
		.head      (head),
		.not_empty (not_empty),
		.empty     (queue_empty)
	);

	sdram_port u_sdram_port (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.head        (head),
		.not_empty   (not_empty),
		.queue_empty (queue_empty),
		.push        (push),
		.sdram_ack   (sdram_ack),
		.sdram_dout  (sdram_dout),
		.pop         (pop),
		.sdram_req   (sdram_req),
		.sdram_addr  (sdram_addr),
		.sdram_we    (sdram_we),
		.sdram_din   (sdram_din),
		.ram_ready   (ram_ready),
		.ram_dout    (ram_dout)
	);

endmodule

//--- src/sdram_port.sv
/*
 * SDRAM request port
 * Toggle req/ack handshake, byte lane select and CPU ready
 */
`timescale 1ns/100ps

module sdram_port (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_mem_pkg::mem_req_t  head,
	input  logic                  not_empty,
	input  logic                  queue_empty,
	input  logic                  push,
	input  logic                  sdram_ack,
	input  logic [15:0]           sdram_dout,
	output logic                  pop,
	output logic                  sdram_req,
	output zx_mem_pkg::ram_addr_t sdram_addr,
	output logic                  sdram_we,
	output logic [7:0]            sdram_din,
	output logic                  ram_ready,
	output logic [7:0]            ram_dout
);

	logic busy;      // Request outstanding at the controller
	logic launch;
	logic done;

	assign launch = ~busy & not_empty;
	assign done   = busy & (sdram_ack == sdram_req);
	assign pop    = launch;

	// CPU may go on only once nothing is left anywhere in the path
	assign ram_ready = queue_empty & ~busy & ~push;

	// ==================================================
	// Handshake control
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy      <= 1'b0;
			sdram_req <= 1'b0;
		end else if (launch) begin
			busy      <= 1'b1;
			sdram_req <= ~sdram_req;    // Toggle starts a new cycle
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	// Held stable until the controller acknowledges
	always_ff @(posedge clk_sys) begin
		if (launch) begin
			sdram_addr <= head.addr;
			sdram_we   <= head.we;
			sdram_din  <= head.data;
		end
	end

	// ==================================================
	// Read data return
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (done & ~sdram_we) begin
			ram_dout <= sdram_addr[0] ? sdram_dout[15:8] : sdram_dout[7:0];    // Odd byte high
		end
	end

	// Controller latches address and data any time before ack
	assert property (@(posedge clk_sys) disable iff (reset)
		sdram_req != sdram_ack |=>
			$stable(sdram_addr) && $stable(sdram_we) && $stable(sdram_din));

endmodule

//--- src/mem_req_queue.sv
/*
 * Pending memory request FIFO
 * Circular buffer with fall-through when empty
 */
`timescale 1ns/100ps

module mem_req_queue #(
	parameter int DEPTH = 4
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 push,
	input  zx_mem_pkg::mem_req_t push_req,
	input  logic                 pop,
	output zx_mem_pkg::mem_req_t head,
	output logic                 not_empty,
	output logic                 empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	zx_mem_pkg::mem_req_t fifo_mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 full;
	logic                 bypass;
	logic                 do_write;
	logic                 do_read;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	// Empty queue hands the incoming request straight to the port
	assign bypass    = empty & push & pop;
	assign do_write  = push & ~bypass & (~full | pop);
	assign do_read   = pop & ~empty;
	assign not_empty = ~empty | push;
	assign head      = empty ? push_req : fifo_mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) wr_ptr <= next_ptr(wr_ptr);
			if (do_read) rd_ptr <= next_ptr(rd_ptr);
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_write) fifo_mem[wr_ptr] <= push_req;
	end

	// Producer is expected to wait on ram_ready before overrunning
	assert property (@(posedge clk_sys) disable iff (reset) push |-> !full || pop);

	assert property (@(posedge clk_sys) disable iff (reset) pop |-> not_empty);

endmodule

//--- paging/page_regs.sv
/*
 * Paging unit
 * 7FFD and 1FFD registers, port decode, bus edge detect
 * and generation of mapped memory requests
 */
`timescale 1ns/100ps
`include "zx_settings.svh"

module page_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_bus_pkg::cpu_bus_t  cpu_bus,
	input  zx_bus_pkg::mem_mode_e mem_mode,
	output logic                  push,
	output zx_mem_pkg::mem_req_t  push_req
);

	localparam int REGION_LSB = `ZX_OFFSET_W + `ZX_BANK_W;

	logic                  zx48_mode;
	logic                  plus3_mode;
	logic [7:0]            page_7ffd;
	logic [7:0]            page_1ffd;
	logic                  io_wr;
	logic                  mem_rd;
	logic                  mem_wr;
	logic                  old_io_wr;
	logic                  old_mem_rd;
	logic                  old_mem_wr;
	logic                  io_wr_edge;
	logic                  rd_edge;
	logic                  wr_edge;
	logic                  page_disable;
	logic                  sel_7ffd;
	logic                  sel_1ffd;
	zx_mem_pkg::ram_addr_t map_addr;
	logic                  write_ok;

	assign io_wr  = cpu_bus.iorq & cpu_bus.wr & ~cpu_bus.m1;
	assign mem_rd = cpu_bus.mreq & cpu_bus.rd;
	assign mem_wr = cpu_bus.mreq & cpu_bus.wr;

	assign io_wr_edge = io_wr & ~old_io_wr;
	assign rd_edge    = mem_rd & ~old_mem_rd;
	assign wr_edge    = mem_wr & ~old_mem_wr;

	// 48K never pages, 128K locks itself via bit 5
	assign page_disable = zx48_mode | page_7ffd[5];

	// +3 also needs A14 so that 1FFD does not alias onto 7FFD
	assign sel_7ffd = ~cpu_bus.addr[15] & ~cpu_bus.addr[1] & (cpu_bus.addr[14] | ~plus3_mode);
	assign sel_1ffd = plus3_mode & ~cpu_bus.addr[15] & ~cpu_bus.addr[14] &
		~cpu_bus.addr[13] & cpu_bus.addr[12] & ~cpu_bus.addr[1];

	mem_map u_mem_map (
		.cpu_addr  (cpu_bus.addr),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd),
		.zx48      (zx48_mode),
		.plus3     (plus3_mode),
		.ram_addr  (map_addr),
		.write_ok  (write_ok)
	);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_io_wr  <= 1'b0;
			old_mem_rd <= 1'b0;
			old_mem_wr <= 1'b0;
		end else begin
			old_io_wr  <= io_wr;
			old_mem_rd <= mem_rd;
			old_mem_wr <= mem_wr;
		end
	end

	// ==================================================
	// Paging registers
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx48_mode  <= (mem_mode == zx_bus_pkg::zx48);    // Mode only taken at reset
			plus3_mode <= (mem_mode == zx_bus_pkg::plus3);
			page_7ffd  <= '0;
			page_1ffd  <= '0;
		end else if (io_wr_edge & ~page_disable) begin
			if (sel_7ffd) begin
				page_7ffd <= cpu_bus.data;
			end else if (sel_1ffd) begin
				page_1ffd <= cpu_bus.data;
			end
		end
	end

	// ==================================================
	// Request generation, one cycle after the bus edge
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			push <= 1'b0;
		end else begin
			push <= rd_edge | (wr_edge & write_ok);    // ROM writes dropped here
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_edge | wr_edge) begin
			push_req.addr <= map_addr;
			push_req.data <= cpu_bus.data;
			push_req.we   <= wr_edge;
		end
	end

	// No queued write may land in the ROM region of SDRAM
	assert property (@(posedge clk_sys) disable iff (reset)
		push && push_req.we |-> push_req.addr[REGION_LSB +: 3] != `ZX_ROM_PREFIX);

	// 1FFD only exists on the +3
	assert property (@(posedge clk_sys) disable iff (reset)
		!plus3_mode |=> $stable(page_1ffd));

endmodule

//--- paging/mem_map.sv
/*
 * CPU to SDRAM address translation
 * ROM bank select, +3 all-RAM modes and ROM write protect
 */
`timescale 1ns/100ps
`include "zx_settings.svh"

module mem_map (
	input  logic [15:0]           cpu_addr,
	input  logic [7:0]            page_7ffd,
	input  logic [7:0]            page_1ffd,
	input  logic                  zx48,
	input  logic                  plus3,
	output zx_mem_pkg::ram_addr_t ram_addr,
	output logic                  write_ok
);

	localparam int PAD_W = `ZX_RAM_ADDR_W - 3 - `ZX_BANK_W - `ZX_OFFSET_W;

	logic [1:0]        window;
	logic              special;
	logic              is_rom;
	zx_mem_pkg::bank_t rom_bank;
	zx_mem_pkg::bank_t ram_bank;
	zx_mem_pkg::bank_t bank;
	logic [2:0]        region;

	assign window  = cpu_addr[15:14];
	assign special = page_1ffd[0];    // +3 all-RAM
	assign is_rom  = ~special & (window == 2'd0);

	// 48K at 15, 128K at 6/7, +3 at 8..11
	always_comb begin
		if (zx48) begin
			rom_bank = 4'd15;
		end else if (plus3) begin
			rom_bank = {2'b10, page_1ffd[2], page_7ffd[4]};
		end else begin
			rom_bank = {3'b011, page_7ffd[4]};
		end
	end

	always_comb begin
		if (special) begin
			case (page_1ffd[2:1])
				2'd0:    ram_bank = {2'b00, window};                          // 0 1 2 3
				2'd1:    ram_bank = {2'b01, window};                          // 4 5 6 7
				2'd2:    ram_bank = (window == 2'd3) ? 4'd3 : {2'b01, window}; // 4 5 6 3
				default: begin                                                // 4 7 6 3
					if (window == 2'd3) ram_bank = 4'd3;
					else if (window == 2'd1) ram_bank = 4'd7;
					else ram_bank = {2'b01, window};
				end
			endcase
		end else begin
			case (window)
				2'd1:    ram_bank = 4'd5;
				2'd2:    ram_bank = 4'd2;
				2'd3:    ram_bank = {1'b0, page_7ffd[2:0]};
				default: ram_bank = 4'd0;    // Window 0 is ROM here
			endcase
		end
	end

	assign region = is_rom ? `ZX_ROM_PREFIX : `ZX_RAM_PREFIX;
	assign bank   = is_rom ? rom_bank : ram_bank;

	assign ram_addr = {{PAD_W{1'b0}}, region, bank, cpu_addr[`ZX_OFFSET_W-1:0]};
	assign write_ok = ~is_rom;

endmodule

//--- common/zx_mem_pkg.sv
/*
 * SDRAM side types
 * Byte address, bank number and queued memory request
 */
`include "zx_settings.svh"

package zx_mem_pkg;

	// Flat byte address into SDRAM
	typedef logic [`ZX_RAM_ADDR_W-1:0] ram_addr_t;

	// 16K bank, ROM or RAM depending on region code
	typedef logic [`ZX_BANK_W-1:0] bank_t;

	// ==================================================
	// One CPU access on its way to SDRAM
	// ==================================================
	typedef struct packed {
		ram_addr_t  addr;
		logic [7:0] data;    // Don't care for reads
		logic       we;
	} mem_req_t;

endpackage

//--- common/zx_bus_pkg.sv
/*
 * CPU side types
 * Z80 bus bundle and the memory mode selection
 */
package zx_bus_pkg;

	// ==================================================
	// Z80 bus as seen by the memory logic
	// ==================================================
	// Strobes are active high here, unlike the pins
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;    // CPU write data
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// ==================================================
	// Machine memory model
	// ==================================================
	typedef enum logic [1:0] {
		std128 = 2'd0,    // 128K / +2
		zx48   = 2'd1,    // Plain 48K, paging locked
		plus3  = 2'd2     // +2A / +3 with 1FFD
	} mem_mode_e;

endpackage

//--- common/zx_settings.svh
/*
 * Memory subsystem constants
 * Address widths, request queue depth and SDRAM region codes
 */
`ifndef ZX_SETTINGS_SVH
`define ZX_SETTINGS_SVH

// SDRAM byte address layout
`define ZX_RAM_ADDR_W   24
`define ZX_BANK_W       4     // 16K bank number
`define ZX_OFFSET_W     14    // Offset inside one 16K window

// Pending CPU requests toward the SDRAM port
`define ZX_REQ_DEPTH    4

// Region code sits just above the bank number
`define ZX_ROM_PREFIX   3'b101
`define ZX_RAM_PREFIX   3'b000

`endif
